// ==== bench/ifu_stim.txt ====
// Header: expected entry count, resolve count. Delays: response wait per request.
// Resolves: npc, flags (bit1 change, bit0 retire). Expected: pc, inst, memory requests so far.
@000
0000001f 00000008
@010
00000000 00000003 00000001 00000005 00000002 00000000 00000007 00000001
00000004 00000002 00000006 00000000 00000003 00000001 00000002 00000005
@020
8000000c 00000001
80000010 00000002
80000010 00000002
80000020 00000002
80000010 00000002
80000020 00000002
8000002c 00000001
80000034 00000001
@040
00100093 00200113 00002183 00400213 00128293 00600313 00700393 fe029ae3
00800413 0000100f fe029463 00900493 00402503 00b00593 00c00613 00d00693
@080
80000000 00100093 00000002
80000004 00200113 00000002
80000008 00002183 00000004
8000000c 00400213 00000004
80000010 00128293 00000006
80000014 00600313 00000006
80000018 00700393 00000008
8000001c fe029ae3 00000008
80000010 00128293 00000008
80000014 00600313 00000008
80000018 00700393 00000008
8000001c fe029ae3 00000008
80000010 00128293 00000008
80000014 00600313 00000008
80000018 00700393 00000008
8000001c fe029ae3 00000008
80000020 00800413 0000000a
80000024 0000100f 0000000a
80000028 fe029463 0000000c
80000010 00128293 00000010
80000014 00600313 00000010
80000018 00700393 00000012
8000001c fe029ae3 00000012
80000020 00800413 00000012
80000024 0000100f 00000012
80000028 fe029463 00000014
8000002c 00900493 00000016
80000030 00402503 00000018
80000034 00b00593 00000018
80000038 00c00613 0000001a
8000003c 00d00693 0000001a

// ==== Bender.yml ====
package:
  name: ifu

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ifu_pkg.sv
      - verilog/l1i_cache.sv
      - verilog/branch_speculator.sv
      - verilog/fetch_ctrl.sv
      - verilog/ifu_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/ifu_mem_model.sv
      - bench/tb_ifu.sv

// ==== sources.f ====
+incdir+verilog
verilog/ifu_pkg.sv
verilog/l1i_cache.sv
verilog/branch_speculator.sv
verilog/fetch_ctrl.sv
verilog/ifu_top.sv
bench/ifu_mem_model.sv
bench/tb_ifu.sv

// ==== bench/tb_ifu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module tb_ifu;

  import ifu_pkg::*;

  // Word offsets of the sections in the stim image
  localparam int RES_BASE = 32;
  localparam int EXP_BASE = 128;

  logic clk;
  logic rst;
  logic mem_req_valid;
  logic mem_req_ready;
  mem_req_t mem_req;
  logic mem_rsp_valid;
  logic mem_rsp_ready;
  mem_rsp_t mem_rsp;
  logic fetch_valid;
  logic fetch_ready;
  fetch_t fetch;
  logic resolve_valid;
  resolve_t resolve;
  logic flush;
  int mem_reqs;

  logic [31:0] stim [0:255];
  int n_exp;
  int n_res;
  int exp_idx;
  int res_idx;
  int cycles;
  int limit;
  int flush_cycle;
  logic btb_valid;
  logic [31:0] btb_target;
  logic spec_wait;
  integer seed;

  ifu_top dut_i (
    .clk             (clk),
    .rst             (rst),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_req_o       (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_ready_o (mem_rsp_ready),
    .mem_rsp_i       (mem_rsp),
    .fetch_valid_o   (fetch_valid),
    .fetch_ready_i   (fetch_ready),
    .fetch_o         (fetch),
    .resolve_valid_i (resolve_valid),
    .resolve_i       (resolve),
    .flush_o         (flush)
  );

  ifu_mem_model mem_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .req_i       (mem_req),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_ready_i (mem_rsp_ready),
    .rsp_o       (mem_rsp),
    .req_count_o (mem_reqs)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  function automatic logic is_transfer(input logic [31:0] inst);
    logic [6:0] op;
    op = inst[6:0];
    return op == `IFU_OP_JAL || op == `IFU_OP_JALR ||
           op == `IFU_OP_BRANCH || op == `IFU_OP_SYSTEM;
  endfunction

  // Next entry of the expected stream, with the memory requests seen so far
  task automatic check_entry();
    check_value("fetch_o.pc", fetch.pc, stim[EXP_BASE + 3 * exp_idx]);
    check_value("fetch_o.inst", fetch.inst, stim[EXP_BASE + 3 * exp_idx + 1]);
    check_value("mem_req_count", mem_reqs, stim[EXP_BASE + 3 * exp_idx + 2]);
    exp_idx++;
  endtask

  task automatic apply_resolve();
    logic [31:0] npc;
    logic [31:0] flags;
    if (res_idx >= n_res) begin
      $display("The resolve script ran out before the fetch stream ended");
      $display("test failed");
      $fatal(1);
    end
    npc = stim[RES_BASE + 2 * res_idx];
    flags = stim[RES_BASE + 2 * res_idx + 1];
    resolve_valid <= 1'b1;
    resolve <= '{npc: npc, change: flags[1], retire: flags[0]};
    if (flags[1]) begin
      btb_valid = 1'b1;
      btb_target = npc;
    end
    res_idx++;
  endtask

  initial begin : run
    logic bad;
    seed = 32'h9d4b_d427;
    rst = 1'b1;
    fetch_ready = 1'b0;
    resolve_valid = 1'b0;
    resolve = '0;
    exp_idx = 0;
    res_idx = 0;
    cycles = 0;
    flush_cycle = -1;
    btb_valid = 1'b0;
    btb_target = '0;
    spec_wait = 1'b0;
    $readmemh("bench/ifu_stim.txt", stim);
    n_exp = stim[0];
    n_res = stim[1];
    limit = 400 * n_exp;

    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      if (i > 0) begin
        check_value("fetch_valid_o", fetch_valid, 0);
        check_value("mem_req_valid_o", mem_req_valid, 0);
        check_value("flush_o", flush, 0);
        check_value("fetch_o.pc", fetch.pc, `IFU_PC_INIT);
      end
    end
    rst <= 1'b0;

    while (exp_idx < n_exp) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("Timeout after %0d cycles with %0d of %0d fetches seen",
                 cycles, exp_idx, n_exp);
        $display("test failed");
        $fatal(1);
      end
      check_value("flush_o", flush, cycles == flush_cycle);
      resolve_valid <= 1'b0;
      if (fetch_valid && fetch_ready) begin
        if (spec_wait) begin
          // First fetch after a predicted branch, graded by the scripted npc
          spec_wait = 1'b0;
          bad = stim[RES_BASE + 2 * res_idx] != btb_target;
          if (!bad) begin
            check_entry();
          end else begin
            flush_cycle = cycles + 2;
          end
          apply_resolve();
        end else begin
          check_entry();
          if (is_transfer(fetch.inst)) begin
            if (btb_valid) begin
              spec_wait = 1'b1;
            end else begin
              apply_resolve();
            end
          end else if (fetch.inst[6:0] == `IFU_OP_LOAD) begin
            apply_resolve();
          end
        end
      end
      fetch_ready <= ($random(seed) & 3) != 0;
    end

    repeat (4) begin
      @(posedge clk);
      cycles++;
      check_value("flush_o", flush, cycles == flush_cycle);
      resolve_valid <= 1'b0;
    end
    check_value("resolves_used", res_idx, n_res);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/ifu_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module ifu_mem_model (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    req_valid_i,
  output logic                   req_ready_o,
  input  wire ifu_pkg::mem_req_t req_i,
  output logic                   rsp_valid_o,
  input  wire                    rsp_ready_i,
  output ifu_pkg::mem_rsp_t      rsp_o,
  output int                     req_count_o
);

  import ifu_pkg::*;

  localparam int DELAY_BASE = 16;
  localparam int IMG_BASE = 64;

  logic [31:0] stim [0:255];
  logic [31:0] mem [0:63];
  logic [31:0] addr_q;
  logic busy_q;
  int wait_q;
  int gap_q;
  int delay_idx;

  // Words outside the image still differ per address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h6b5e_0013;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `IFU_PC_INIT;
    if (off < 256) begin
      return mem[off[7:2]];
    end
    return fill_word(addr);
  endfunction

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_o = '0;
    $readmemh("bench/ifu_stim.txt", stim);
    for (int i = 0; i < 64; i++) begin
      if ($isunknown(stim[IMG_BASE + i])) begin
        mem[i] = fill_word(`IFU_PC_INIT + 4 * i);
      end else begin
        mem[i] = stim[IMG_BASE + i];
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_o <= '0;
      busy_q <= 1'b0;
      wait_q <= 0;
      gap_q <= 0;
      delay_idx <= 0;
      req_count_o <= 0;
    end else if (req_valid_i && req_ready_o) begin
      req_count_o <= req_count_o + 1;
      req_ready_o <= 1'b0;
      busy_q <= 1'b1;
      addr_q <= req_i.addr;
      wait_q <= stim[DELAY_BASE + delay_idx];
    end else if (busy_q && !rsp_valid_o) begin
      if (wait_q == 0) begin
        rsp_valid_o <= 1'b1;
        rsp_o.data <= read_word(addr_q);
      end else begin
        wait_q <= wait_q - 1;
      end
    end else if (rsp_valid_o && rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
      busy_q <= 1'b0;
      // Short pause with ready low before the next request
      gap_q <= stim[DELAY_BASE + delay_idx] % 3;
      delay_idx <= (delay_idx + 1) % 16;
    end else if (!busy_q) begin
      if (gap_q == 0) begin
        req_ready_o <= 1'b1;
      end else begin
        gap_q <= gap_q - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module ifu_top (
  input  wire                    clk,
  input  wire                    rst,
  output logic                   mem_req_valid_o,
  input  wire                    mem_req_ready_i,
  output ifu_pkg::mem_req_t      mem_req_o,
  input  wire                    mem_rsp_valid_i,
  output logic                   mem_rsp_ready_o,
  input  wire ifu_pkg::mem_rsp_t mem_rsp_i,
  output logic                   fetch_valid_o,
  input  wire                    fetch_ready_i,
  output ifu_pkg::fetch_t        fetch_o,
  input  wire                    resolve_valid_i,
  input  wire ifu_pkg::resolve_t resolve_i,
  output logic                   flush_o
);

  logic [`IFU_ADDR_W-1:0] lookup_pc;
  logic [`IFU_ADDR_W-1:0] inst;
  logic hit;
  logic busy;
  logic flush_cache;

  logic [`IFU_ADDR_W-1:0] target;
  logic target_valid;
  logic spec_active;
  logic spec_bad;
  logic predict;

  l1i_cache l1i_i (
    .clk             (clk),
    .rst             (rst),
    .lookup_pc_i     (lookup_pc),
    .hit_o           (hit),
    .inst_o          (inst),
    .busy_o          (busy),
    .flush_i         (flush_cache),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_ready_o (mem_rsp_ready_o),
    .mem_rsp_i       (mem_rsp_i)
  );

  // Good outcomes need no action in fetch
  branch_speculator spec_i (
    .clk             (clk),
    .rst             (rst),
    .resolve_valid_i (resolve_valid_i),
    .resolve_i       (resolve_i),
    .predict_i       (predict),
    .target_o        (target),
    .target_valid_o  (target_valid),
    .active_o        (spec_active),
    .good_o          (),
    .bad_o           (spec_bad)
  );

  fetch_ctrl ctrl_i (
    .clk             (clk),
    .rst             (rst),
    .hit_i           (hit),
    .inst_i          (inst),
    .busy_i          (busy),
    .lookup_pc_o     (lookup_pc),
    .flush_cache_o   (flush_cache),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_ready_i   (fetch_ready_i),
    .fetch_o         (fetch_o),
    .resolve_valid_i (resolve_valid_i),
    .resolve_i       (resolve_i),
    .target_i        (target),
    .target_valid_i  (target_valid),
    .spec_active_i   (spec_active),
    .spec_bad_i      (spec_bad),
    .predict_o       (predict),
    .flush_o         (flush_o)
  );

endmodule

`default_nettype wire

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module fetch_ctrl (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    hit_i,
  input  wire [`IFU_ADDR_W-1:0]  inst_i,
  input  wire                    busy_i,
  output logic [`IFU_ADDR_W-1:0] lookup_pc_o,
  output logic                   flush_cache_o,
  output logic                   fetch_valid_o,
  input  wire                    fetch_ready_i,
  output ifu_pkg::fetch_t        fetch_o,
  input  wire                    resolve_valid_i,
  input  wire ifu_pkg::resolve_t resolve_i,
  input  wire [`IFU_ADDR_W-1:0]  target_i,
  input  wire                    target_valid_i,
  input  wire                    spec_active_i,
  input  wire                    spec_bad_i,
  output logic                   predict_o,
  output logic                   flush_o
);

  import ifu_pkg::*;

  logic [`IFU_ADDR_W-1:0] pc_q;
  logic hazard_q;
  logic flush_q;

  logic [6:0] opcode;
  fetch_kind_e kind;
  logic fence_wait;
  logic fire;
  logic resolved;

  assign opcode = inst_i[6:0];

  always_comb begin
    if (inst_i == `IFU_INST_FENCE_I) begin
      kind = FENCE;
    end else if (opcode == `IFU_OP_JAL || opcode == `IFU_OP_JALR ||
                 opcode == `IFU_OP_BRANCH || opcode == `IFU_OP_SYSTEM) begin
      kind = BRANCH;
    end else if (opcode == `IFU_OP_LOAD) begin
      kind = LOAD;
    end else begin
      kind = SEQ;
    end
  end

  // Let a line fill settle before fence.i wipes the cache
  assign fence_wait = (kind == FENCE) && busy_i;

  // Nothing goes out in the cycle a misprediction is found
  assign fetch_valid_o = hit_i && !hazard_q && !spec_bad_i && !fence_wait;
  assign fire = fetch_valid_o && fetch_ready_i;

  assign fetch_o.pc = pc_q;
  assign fetch_o.inst = inst_i;
  assign lookup_pc_o = pc_q;

  assign resolved = resolve_valid_i && (resolve_i.change || resolve_i.retire);
  assign predict_o = fire && (kind == BRANCH) && target_valid_i && !spec_active_i;
  assign flush_cache_o = fire && (kind == FENCE);
  assign flush_o = flush_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `IFU_PC_INIT;
      hazard_q <= 1'b0;
      flush_q <= 1'b0;
    end else begin
      flush_q <= spec_bad_i;
      if (spec_bad_i) begin
        pc_q <= resolve_i.npc;
        hazard_q <= 1'b0;
      end else if (hazard_q && resolved && !spec_active_i) begin
        // A resolve during speculation belongs to the predicted branch
        pc_q <= resolve_i.npc;
        hazard_q <= 1'b0;
      end else if (fire) begin
        unique case (kind)
          BRANCH: begin
            if (target_valid_i && !spec_active_i) begin
              pc_q <= target_i;
            end else begin
              hazard_q <= 1'b1;
            end
          end
          LOAD: begin
            hazard_q <= 1'b1;
          end
          default: begin
            pc_q <= pc_q + `IFU_ADDR_W'(4);
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/branch_speculator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module branch_speculator (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    resolve_valid_i,
  input  wire ifu_pkg::resolve_t resolve_i,
  input  wire                    predict_i,
  output logic [`IFU_ADDR_W-1:0] target_o,
  output logic                   target_valid_o,
  output logic                   active_o,
  output logic                   good_o,
  output logic                   bad_o
);

  logic resolved;

  // One-entry target buffer
  logic [`IFU_ADDR_W-1:0] target_q;
  logic target_valid_q;

  // Target fetch went to on the open prediction
  logic [`IFU_ADDR_W-1:0] spec_target_q;
  logic active_q;

  assign resolved = resolve_valid_i && (resolve_i.change || resolve_i.retire);

  assign target_o = target_q;
  assign target_valid_o = target_valid_q;
  assign active_o = active_q;

  // Graded in the cycle the resolve arrives
  assign good_o = active_q && resolved && (resolve_i.npc == spec_target_q);
  assign bad_o = active_q && resolved && (resolve_i.npc != spec_target_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      target_valid_q <= 1'b0;
      active_q <= 1'b0;
    end else begin
      if (resolved && resolve_i.change) begin
        target_valid_q <= 1'b1;
      end
      if (predict_i) begin
        active_q <= 1'b1;
      end else if (active_q && resolved) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resolved && resolve_i.change) begin
      target_q <= resolve_i.npc;
    end
    if (predict_i) begin
      spec_target_q <= target_q;
    end
  end

  a_good_bad_excl: assert property (@(posedge clk) disable iff (rst)
    !(good_o && bad_o));

  // Fetch never stacks a second prediction on an open one
  a_no_nested_predict: assert property (@(posedge clk) disable iff (rst)
    predict_i |-> !active_q);

endmodule

`default_nettype wire

// ==== verilog/l1i_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_defs.svh"

module l1i_cache (
  input  wire                    clk,
  input  wire                    rst,
  input  wire [`IFU_ADDR_W-1:0]  lookup_pc_i,
  output logic                   hit_o,
  output logic [`IFU_ADDR_W-1:0] inst_o,
  output logic                   busy_o,
  input  wire                    flush_i,
  output logic                   mem_req_valid_o,
  input  wire                    mem_req_ready_i,
  output ifu_pkg::mem_req_t      mem_req_o,
  input  wire                    mem_rsp_valid_i,
  output logic                   mem_rsp_ready_o,
  input  wire ifu_pkg::mem_rsp_t mem_rsp_i
);

  localparam int SETS = 1 << `IFU_L1I_SETS_LOG;
  localparam int WORDS = 1 << `IFU_L1I_WORDS_LOG;
  localparam int IDX_LSB = 2 + `IFU_L1I_WORDS_LOG;
  localparam int TAG_LSB = IDX_LSB + `IFU_L1I_SETS_LOG;
  localparam int TAG_W = `IFU_ADDR_W - TAG_LSB;

  typedef enum logic [2:0] {
    IDLE,
    REQ0,
    RSP0,
    REQ1,
    RSP1,
    FILL
  } state_e;

  state_e state_q;

  logic [`IFU_ADDR_W-1:0] data_q [SETS][WORDS];
  logic [TAG_W-1:0] tag_q [SETS];
  logic [SETS-1:0] valid_q;

  logic [TAG_W-1:0] pc_tag;
  logic [`IFU_L1I_SETS_LOG-1:0] pc_idx;
  logic [`IFU_L1I_WORDS_LOG-1:0] pc_off;

  // Line under refill is latched when the miss is taken
  logic [TAG_W-1:0] fill_tag_q;
  logic [`IFU_L1I_SETS_LOG-1:0] fill_idx_q;
  logic [`IFU_L1I_WORDS_LOG-1:0] req_word;

  assign pc_tag = lookup_pc_i[`IFU_ADDR_W-1:TAG_LSB];
  assign pc_idx = lookup_pc_i[TAG_LSB-1:IDX_LSB];
  assign pc_off = lookup_pc_i[IDX_LSB-1:2];

  // A freshly filled line is already visible in FILL
  assign hit_o = (state_q == IDLE || state_q == FILL) && valid_q[pc_idx] &&
                 (tag_q[pc_idx] == pc_tag);
  assign inst_o = data_q[pc_idx][pc_off];
  assign busy_o = (state_q != IDLE);

  // Even word goes out before the odd word
  assign req_word = (state_q == REQ1) ? `IFU_L1I_WORDS_LOG'(1) : '0;
  assign mem_req_valid_o = (state_q == REQ0) || (state_q == REQ1);
  assign mem_req_o.addr = {fill_tag_q, fill_idx_q, req_word, 2'b00};
  assign mem_rsp_ready_o = (state_q == RSP0) || (state_q == RSP1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (!hit_o) begin
            state_q <= REQ0;
          end
        end
        REQ0: begin
          if (mem_req_ready_i) begin
            state_q <= RSP0;
          end
        end
        RSP0: begin
          if (mem_rsp_valid_i) begin
            state_q <= REQ1;
          end
        end
        REQ1: begin
          if (mem_req_ready_i) begin
            state_q <= RSP1;
          end
        end
        RSP1: begin
          if (mem_rsp_valid_i) begin
            state_q <= FILL;
            valid_q[fill_idx_q] <= 1'b1;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
      // fence.i drops every line
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      fill_tag_q <= pc_tag;
      fill_idx_q <= pc_idx;
    end
    if (state_q == RSP0 && mem_rsp_valid_i) begin
      data_q[fill_idx_q][0] <= mem_rsp_i.data;
    end
    if (state_q == RSP1 && mem_rsp_valid_i) begin
      data_q[fill_idx_q][1] <= mem_rsp_i.data;
      tag_q[fill_idx_q] <= fill_tag_q;
    end
  end

  // No new request until the pending response arrives
  a_no_req_in_rsp: assert property (@(posedge clk) disable iff (rst)
    ((mem_req_valid_o && mem_req_ready_i) || (mem_rsp_ready_o && !mem_rsp_valid_i))
    |=> !mem_req_valid_o);

  a_req_addr_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)));

endmodule

`default_nettype wire

// ==== verilog/ifu_pkg.sv ====
`default_nettype none

`include "ifu_defs.svh"

package ifu_pkg;

  // Word address on the memory read channel
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] addr;
  } mem_req_t;

  // Read data word
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] data;
  } mem_rsp_t;

  // Fetched instruction handed to decode
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] pc;
    logic [`IFU_ADDR_W-1:0] inst;
  } fetch_t;

  // Actual next pc from the back end
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] npc;
    logic change;
    logic retire;
  } resolve_t;

  // How an accepted instruction moves the pc
  typedef enum logic [1:0] {
    SEQ,
    BRANCH,
    LOAD,
    FENCE
  } fetch_kind_e;

endpackage

`default_nettype wire

// ==== verilog/ifu_defs.svh ====
`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// Address and data width
`define IFU_ADDR_W 32

// First fetch address out of reset
`define IFU_PC_INIT 32'h8000_0000

// L1I geometry, four lines of two words
`define IFU_L1I_SETS_LOG 2
`define IFU_L1I_WORDS_LOG 1

// RV32 major opcodes that change fetch flow
`define IFU_OP_JAL 7'b1101111
`define IFU_OP_JALR 7'b1100111
`define IFU_OP_BRANCH 7'b1100011
`define IFU_OP_SYSTEM 7'b1110011

// Loads hold fetch until resolved
`define IFU_OP_LOAD 7'b0000011

// fence.i with rd, rs1 and imm all zero
`define IFU_INST_FENCE_I 32'h0000_100f

`endif
